//--- cpu_datapath.f
design/lc3b_types_pkg.sv
design/lc3b_ctrl_pkg.sv
design/if_datapath.sv
design/buffer.sv
design/id_datapath.sv
design/ex_datapath.sv
design/mem_datapath.sv
design/cpu_datapath.sv
bench/cpu_tb_mem.sv
bench/cpu_datapath_tb.sv

//--- Makefile
# Verilator build for the LC-3b pipeline testbench

VERILATOR ?= verilator
TOP       ?= cpu_datapath_tb
FILELIST  ?= cpu_datapath.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/cpu_datapath_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath_tb;

    logic clk;
    logic rst_n;
    logic resp_a;
    logic resp_b;
    lc3b_types_pkg::lc3b_word rdata_a;
    lc3b_types_pkg::lc3b_word rdata_b;
    logic read_a;
    logic write_a;
    logic read_b;
    logic write_b;
    logic [1:0] wmask_a;
    logic [1:0] wmask_b;
    lc3b_types_pkg::lc3b_word address_a;
    lc3b_types_pkg::lc3b_word address_b;
    lc3b_types_pkg::lc3b_word wdata_a;
    lc3b_types_pkg::lc3b_word wdata_b;

    logic [15:0] prog [$];
    logic [15:0] image [256];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    int seen;
    int cycles;
    int limit;

    cpu_datapath uut (
        .clk(clk), .rst_n(rst_n),
        .resp_a(resp_a), .rdata_a(rdata_a), .read_a(read_a), .write_a(write_a),
        .wmask_a(wmask_a), .address_a(address_a), .wdata_a(wdata_a),
        .resp_b(resp_b), .rdata_b(rdata_b), .read_b(read_b), .write_b(write_b),
        .wmask_b(wmask_b), .address_b(address_b), .wdata_b(wdata_b)
    );

    cpu_tb_mem mem_model (
        .clk(clk), .rst_n(rst_n),
        .read_a(read_a), .address_a(address_a), .resp_a(resp_a), .rdata_a(rdata_a),
        .read_b(read_b), .write_b(write_b), .address_b(address_b), .wdata_b(wdata_b),
        .resp_b(resp_b), .rdata_b(rdata_b)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        report_fail($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    endtask

    // instruction encoders
    function automatic logic [15:0] alu_reg(input logic [3:0] op, input int dr, input int s1,
                                            input int s2);
        return {op, 3'(dr), 3'(s1), 3'b000, 3'(s2)};
    endfunction

    function automatic logic [15:0] alu_imm(input logic [3:0] op, input int dr, input int s1,
                                            input int imm);
        return {op, 3'(dr), 3'(s1), 1'b1, 5'(imm)};
    endfunction

    function automatic logic [15:0] not_op(input int dr, input int sr);
        return {4'b1001, 3'(dr), 3'(sr), 6'h3f};
    endfunction

    function automatic logic [15:0] mem_op(input logic [3:0] op, input int r, input int base,
                                           input int off);
        return {op, 3'(r), 3'(base), 6'(off)};
    endfunction

    function automatic logic [15:0] br_op(input logic [2:0] nzp, input int off);
        return {4'b0000, nzp, 9'(off)};
    endfunction

    function automatic logic [15:0] sext(input logic [15:0] v, input int bits);
        logic [15:0] m;
        m = 16'hffff << bits;
        if (v[bits-1]) begin
            return v | m;
        end
        return v & ~m;
    endfunction

    task automatic emit(input logic [15:0] w);
        prog.push_back(w);
    endtask

    task automatic nops(input int n);
        for (int i = 0; i < n; i++) begin
            emit(16'h0000);
        end
    endtask

    task automatic build_program();
        emit(alu_imm(4'b0001, 1, 0, 7));
        emit(alu_imm(4'b0001, 2, 0, -3));
        emit(mem_op(4'b0110, 3, 0, -32));
        nops(3);
        emit(alu_reg(4'b0001, 4, 1, 2));
        emit(alu_reg(4'b0101, 5, 1, 2));
        emit(not_op(6, 3));
        emit(alu_imm(4'b0001, 7, 2, 5));
        emit(alu_imm(4'b0101, 2, 3, 12));
        nops(3);
        for (int r = 2; r < 8; r++) begin
            emit(mem_op(4'b0111, r, 0, -33 + r));
        end
        // R1 goes negative so BRz falls through and BRn skips one store
        emit(alu_imm(4'b0001, 1, 0, -1));
        emit(br_op(3'b010, 4));
        nops(3);
        emit(mem_op(4'b0111, 1, 0, -25));
        emit(br_op(3'b100, 4));
        nops(3);
        emit(mem_op(4'b0111, 1, 0, -24));
        emit(mem_op(4'b0111, 4, 0, -23));
        // spin on itself
        emit(br_op(3'b111, -1));
        nops(3);
    endtask

    // ISA model with three delay slots after a taken BR
    task automatic run_model();
        logic [15:0] r [8];
        logic [15:0] ins;
        logic [15:0] opb;
        logic [15:0] res;
        logic [15:0] addr;
        logic [2:0] cc;
        int pc;
        int next;
        int tgt;
        int slots;
        bit wr;
        bit done;
        for (int i = 0; i < 8; i++) begin
            r[i] = 16'h0000;
        end
        cc = 3'b010;
        pc = 0;
        tgt = 0;
        slots = 0;
        done = 0;
        for (int steps = 0; steps < 1000 && !done; steps++) begin
            ins = image[pc];
            wr = 0;
            res = 16'h0000;
            next = pc + 1;
            addr = r[ins[8:6]] + (sext(ins, 6) << 1);
            opb = ins[5] ? sext(ins, 5) : r[ins[2:0]];
            case (ins[15:12])
                4'b0001: begin
                    res = r[ins[8:6]] + opb;
                    wr = 1;
                end
                4'b0101: begin
                    res = r[ins[8:6]] & opb;
                    wr = 1;
                end
                4'b1001: begin
                    res = ~r[ins[8:6]];
                    wr = 1;
                end
                4'b0110: begin
                    res = image[addr[8:1]];
                    wr = 1;
                end
                4'b0111: begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(r[ins[11:9]]);
                    image[addr[8:1]] = r[ins[11:9]];
                end
                default: begin
                    if ((ins[11:9] & cc) != 3'b000) begin
                        tgt = pc + 1 + int'($signed(sext(ins, 9)));
                        done = (tgt == pc);
                        slots = 4;
                    end
                end
            endcase
            if (wr) begin
                r[ins[11:9]] = res;
                cc = res[15] ? 3'b100 : (res == 16'h0000 ? 3'b010 : 3'b001);
            end
            if (slots > 0) begin
                slots--;
                if (slots == 0) begin
                    next = tgt;
                end
            end
            pc = next;
        end
    endtask

    // port B must be idle through reset
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!read_b && !write_b)
                else report_fail("port B request raised during reset");
        end
    end

    // every completed write must match the next expected store
    always @(negedge clk) begin
        if (rst_n && resp_b && write_b) begin
            if (seen >= exp_addr.size()) begin
                report_fail($sformatf("unexpected extra store to %h", address_b));
            end else begin
                assert (address_b == exp_addr[seen])
                    else report_value($sformatf("store %0d address", seen),
                                      exp_addr[seen], address_b);
                assert (wdata_b == exp_data[seen])
                    else report_value($sformatf("store %0d data", seen),
                                      exp_data[seen], wdata_b);
                seen = seen + 1;
            end
        end
    end

    // port A only fetches and both ports move full words
    always @(negedge clk) begin
        if (rst_n) begin
            assert (read_a)
                else report_fail("port A stopped fetching");
            assert (!write_a)
                else report_fail("write raised on port A");
            assert (wdata_a == 16'h0000)
                else report_value("port A write data", 16'h0000, wdata_a);
            assert (wmask_a == 2'b11)
                else report_value("port A write mask", 16'h0003, 16'(wmask_a));
            assert (wmask_b == 2'b11)
                else report_value("port B write mask", 16'h0003, 16'(wmask_b));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            report_fail($sformatf("timeout with a store missing, %0d of %0d stores seen",
                                  seen, exp_addr.size()));
        end
    end

    initial begin
        rst_n = 1'b0;
        seen = 0;
        cycles = 0;
        limit = 0;
        for (int i = 0; i < 256; i++) begin
            image[i] = 16'h0000;
        end
        build_program();
        foreach (prog[i]) begin
            image[i] = prog[i];
        end
        // data word for the LDR at 0xffc0
        image[8'he0] = 16'ha5c3;
        run_model();
        limit = 40 * prog.size();
        @(posedge clk);
        foreach (prog[i]) begin
            mem_model.load_word(16'(2 * i), prog[i]);
        end
        mem_model.load_word(16'hffc0, 16'ha5c3);
        repeat (7) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!read_b && !write_b)
            else report_fail("port B request right after reset");
        assert (address_a == 16'h0000)
            else report_value("first fetch address", 16'h0000, address_a);
        while (seen < exp_addr.size()) begin
            @(posedge clk);
        end
        // let the spin loop run to catch stray stores
        repeat (20) @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule : cpu_datapath_tb

`default_nettype wire

//--- bench/cpu_tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb_mem (
    input logic clk,
    input logic rst_n,

    // port A
    input logic read_a,
    input lc3b_types_pkg::lc3b_word address_a,
    output logic resp_a,
    output lc3b_types_pkg::lc3b_word rdata_a,

    // port B
    input logic read_b,
    input logic write_b,
    input lc3b_types_pkg::lc3b_word address_b,
    input lc3b_types_pkg::lc3b_word wdata_b,
    output logic resp_b,
    output lc3b_types_pkg::lc3b_word rdata_b
);

    lc3b_types_pkg::lc3b_word words [256];
    logic [1:0] wait_a;
    logic [1:0] wait_b;
    integer seed;
    logic [31:0] draw_a;
    logic [31:0] draw_b;

    // pattern over the whole word index
    initial begin
        seed = 35961;
        for (int i = 0; i < 256; i++) begin
            words[i] = {8'(i) ^ 8'h3c, 8'(i)};
        end
    end

    task automatic load_word(input lc3b_types_pkg::lc3b_word addr, input lc3b_types_pkg::lc3b_word data);
        words[addr[8:1]] = data;
    endtask

    // respond once the delay counter has run out
    assign resp_a = read_a && (wait_a == 2'd0);
    assign resp_b = (read_b || write_b) && (wait_b == 2'd0);
    assign rdata_a = words[address_a[8:1]];
    assign rdata_b = words[address_b[8:1]];

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_a <= 2'd0;
            wait_b <= 2'd0;
        end else begin
            // a fresh delay of 0 to 3 cycles for the next request
            if (resp_a) begin
                draw_a = $random(seed);
                wait_a <= draw_a[1:0];
            end else if (read_a) begin
                wait_a <= wait_a - 2'd1;
            end
            if (resp_b) begin
                draw_b = $random(seed);
                wait_b <= draw_b[1:0];
            end else if (read_b || write_b) begin
                wait_b <= wait_b - 2'd1;
            end
            if (resp_b && write_b) begin
                words[address_b[8:1]] <= wdata_b;
            end
        end
    end

endmodule : cpu_tb_mem

`default_nettype wire

//--- design/cpu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath (
    input logic clk,
    input logic rst_n,

    // port A
    input logic resp_a,
    input lc3b_types_pkg::lc3b_word rdata_a,
    output logic read_a,
    output logic write_a,
    output logic [1:0] wmask_a,
    output lc3b_types_pkg::lc3b_word address_a,
    output lc3b_types_pkg::lc3b_word wdata_a,

    // port B
    input logic resp_b,
    input lc3b_types_pkg::lc3b_word rdata_b,
    output logic read_b,
    output logic write_b,
    output logic [1:0] wmask_b,
    output lc3b_types_pkg::lc3b_word address_b,
    output lc3b_types_pkg::lc3b_word wdata_b
);

    logic stall;
    lc3b_ctrl_pkg::lc3b_pcmux_sel pcmux_sel;
    lc3b_types_pkg::lc3b_word pc_br;

    lc3b_ctrl_pkg::if_id_t if_out;
    lc3b_ctrl_pkg::if_id_t if_id;
    lc3b_ctrl_pkg::id_ex_t id_out;
    lc3b_ctrl_pkg::id_ex_t id_ex;
    lc3b_ctrl_pkg::ex_mem_t ex_out;
    lc3b_ctrl_pkg::ex_mem_t ex_mem;
    lc3b_ctrl_pkg::mem_wb_t mem_out;
    lc3b_ctrl_pkg::mem_wb_t mem_wb;

    // port A is read only, full words on both ports
    assign write_a = 1'b0;
    assign wdata_a = '0;
    assign wmask_a = 2'b11;
    assign wmask_b = 2'b11;

    // any outstanding access freezes every stage
    assign stall = (read_a && !resp_a) || ((read_b || write_b) && !resp_b);

    if_datapath if_data (
        .clk(clk),
        .rst_n(rst_n),
        .resp_a(resp_a),
        .rdata_a(rdata_a),
        .read_a(read_a),
        .address_a(address_a),
        .stall(stall),
        .pcmux_sel(pcmux_sel),
        .pc_br(pc_br),
        .if_out(if_out)
    );

    buffer #(.stage_t(lc3b_ctrl_pkg::if_id_t)) if_id_buf (
        .clk(clk),
        .rst_n(rst_n),
        .load(~stall),
        .data_in(if_out),
        .data_out(if_id)
    );

    id_datapath id (
        .clk(clk),
        .rst_n(rst_n),
        .if_id(if_id),
        .wb(mem_wb),
        .id_out(id_out)
    );

    buffer #(.stage_t(lc3b_ctrl_pkg::id_ex_t)) id_ex_buf (
        .clk(clk),
        .rst_n(rst_n),
        .load(~stall),
        .data_in(id_out),
        .data_out(id_ex)
    );

    ex_datapath ex (
        .id_ex(id_ex),
        .ex_out(ex_out)
    );

    buffer #(.stage_t(lc3b_ctrl_pkg::ex_mem_t)) ex_mem_buf (
        .clk(clk),
        .rst_n(rst_n),
        .load(~stall),
        .data_in(ex_out),
        .data_out(ex_mem)
    );

    // the branch decision reaches fetch through pcmux_sel
    mem_datapath mem (
        .clk(clk),
        .rst_n(rst_n),
        .resp_b(resp_b),
        .rdata_b(rdata_b),
        .ex_mem(ex_mem),
        .stall(stall),
        .read_b(read_b),
        .write_b(write_b),
        .address_b(address_b),
        .wdata_b(wdata_b),
        .br_en(),
        .pcmux_sel(pcmux_sel),
        .pc_br(pc_br),
        .mem_out(mem_out)
    );

    buffer #(.stage_t(lc3b_ctrl_pkg::mem_wb_t)) mem_wb_buf (
        .clk(clk),
        .rst_n(rst_n),
        .load(~stall),
        .data_in(mem_out),
        .data_out(mem_wb)
    );

endmodule : cpu_datapath

`default_nettype wire

//--- design/mem_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module mem_datapath (
    input logic clk,
    input logic rst_n,

    // port B, data side
    input logic resp_b,
    input lc3b_types_pkg::lc3b_word rdata_b,

    input lc3b_ctrl_pkg::ex_mem_t ex_mem,
    input logic stall,

    output logic read_b,
    output logic write_b,
    output lc3b_types_pkg::lc3b_word address_b,
    output lc3b_types_pkg::lc3b_word wdata_b,

    output logic br_en,
    output lc3b_ctrl_pkg::lc3b_pcmux_sel pcmux_sel,
    output lc3b_types_pkg::lc3b_word pc_br,

    output lc3b_ctrl_pkg::mem_wb_t mem_out
);

    lc3b_types_pkg::lc3b_nzp cc;
    lc3b_types_pkg::lc3b_nzp cc_next;
    lc3b_types_pkg::lc3b_word dest_data;
    lc3b_types_pkg::lc3b_word rdata_q;
    logic mem_done;

    // access already answered while the pipeline is frozen elsewhere
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_done <= 1'b0;
        end else if (!stall) begin
            mem_done <= 1'b0;
        end else if (resp_b && (read_b || write_b)) begin
            mem_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_b && read_b) begin
            rdata_q <= rdata_b;
        end
    end

    assign read_b = ex_mem.ctrl.mem_read && !mem_done;
    assign write_b = ex_mem.ctrl.mem_write && !mem_done;
    assign address_b = ex_mem.alu;
    assign wdata_b = ex_mem.src2_data;

    always_comb begin
        if (!ex_mem.ctrl.mem_read) begin
            dest_data = ex_mem.alu;
        end else if (mem_done) begin
            dest_data = rdata_q;
        end else begin
            dest_data = rdata_b;
        end
    end

    always_comb begin
        if (dest_data[15]) begin
            cc_next = 3'b100;
        end else if (dest_data == '0) begin
            cc_next = 3'b010;
        end else begin
            cc_next = 3'b001;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cc <= 3'b010;
        end else if (ex_mem.ctrl.load_cc && !stall) begin
            cc <= cc_next;
        end
    end

    // nzp field of the BR against the last written value
    assign br_en = ex_mem.ctrl.branch && ((ex_mem.instruction[11:9] & cc) != '0);
    assign pcmux_sel = br_en ? lc3b_ctrl_pkg::pc_branch : lc3b_ctrl_pkg::pc_plus2;
    assign pc_br = ex_mem.pc_br;

    assign mem_out.ctrl = ex_mem.ctrl;
    assign mem_out.dest = ex_mem.dest;
    assign mem_out.dest_data = dest_data;

endmodule : mem_datapath

`default_nettype wire

//--- design/ex_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module ex_datapath (
    input lc3b_ctrl_pkg::id_ex_t id_ex,
    output lc3b_ctrl_pkg::ex_mem_t ex_out
);

    localparam int w = lc3b_types_pkg::word_width;
    localparam int i5 = lc3b_types_pkg::imm5_width;
    localparam int o6 = lc3b_types_pkg::offset6_width;
    localparam int o9 = lc3b_types_pkg::offset9_width;

    lc3b_types_pkg::lc3b_word instr;
    lc3b_types_pkg::lc3b_word imm5_sext;
    lc3b_types_pkg::lc3b_word offset6_sext;
    lc3b_types_pkg::lc3b_word offset9_sext;
    lc3b_types_pkg::lc3b_word operand_b;
    lc3b_types_pkg::lc3b_word alu_out;

    assign instr = id_ex.instruction;

    // offsets are word offsets, so shifted into byte addresses
    assign imm5_sext = {{(w-i5){instr[i5-1]}}, instr[i5-1:0]};
    assign offset6_sext = {{(w-o6-1){instr[o6-1]}}, instr[o6-1:0], 1'b0};
    assign offset9_sext = {{(w-o9-1){instr[o9-1]}}, instr[o9-1:0], 1'b0};

    always_comb begin
        if (id_ex.ctrl.imm_sel) begin
            operand_b = imm5_sext;
        end else if (id_ex.ctrl.offset6_sel) begin
            operand_b = offset6_sext;
        end else begin
            operand_b = id_ex.src2_data;
        end
    end

    always_comb begin
        case (id_ex.ctrl.aluop)
            lc3b_ctrl_pkg::alu_add: alu_out = id_ex.src1_data + operand_b;
            lc3b_ctrl_pkg::alu_and: alu_out = id_ex.src1_data & operand_b;
            lc3b_ctrl_pkg::alu_not: alu_out = ~id_ex.src1_data;
            default: alu_out = id_ex.src1_data;
        endcase
    end

    assign ex_out.ctrl = id_ex.ctrl;
    assign ex_out.pc = id_ex.pc;
    assign ex_out.instruction = instr;
    assign ex_out.dest = id_ex.dest;
    assign ex_out.alu = alu_out;
    // pc is already past the BR
    assign ex_out.pc_br = id_ex.pc + offset9_sext;
    assign ex_out.src2_data = id_ex.src2_data;

endmodule : ex_datapath

`default_nettype wire

//--- design/id_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module id_datapath (
    input logic clk,
    input logic rst_n,
    input lc3b_ctrl_pkg::if_id_t if_id,
    input lc3b_ctrl_pkg::mem_wb_t wb,
    output lc3b_ctrl_pkg::id_ex_t id_out
);

    lc3b_types_pkg::lc3b_word instr;
    lc3b_ctrl_pkg::lc3b_control_word ctrl;
    lc3b_types_pkg::lc3b_reg src1;
    lc3b_types_pkg::lc3b_reg src2;
    lc3b_types_pkg::lc3b_word regs [lc3b_types_pkg::reg_count];

    assign instr = if_id.instruction;

    always_comb begin
        ctrl = '0;
        src1 = instr[8:6];
        src2 = instr[2:0];
        case (lc3b_types_pkg::lc3b_opcode'(instr[15:12]))
            lc3b_types_pkg::op_add, lc3b_types_pkg::op_and: begin
                ctrl.opcode = lc3b_types_pkg::lc3b_opcode'(instr[15:12]);
                if (instr[15:12] == lc3b_types_pkg::op_add) begin
                    ctrl.aluop = lc3b_ctrl_pkg::alu_add;
                end else begin
                    ctrl.aluop = lc3b_ctrl_pkg::alu_and;
                end
                // bit 5 picks imm5 over SR2
                ctrl.imm_sel = instr[5];
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            lc3b_types_pkg::op_not: begin
                ctrl.opcode = lc3b_types_pkg::op_not;
                ctrl.aluop = lc3b_ctrl_pkg::alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            lc3b_types_pkg::op_br: begin
                ctrl.opcode = lc3b_types_pkg::op_br;
                ctrl.aluop = lc3b_ctrl_pkg::alu_pass;
                ctrl.branch = 1'b1;
            end
            lc3b_types_pkg::op_ldr: begin
                ctrl.opcode = lc3b_types_pkg::op_ldr;
                ctrl.aluop = lc3b_ctrl_pkg::alu_add;
                ctrl.offset6_sel = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            lc3b_types_pkg::op_str: begin
                ctrl.opcode = lc3b_types_pkg::op_str;
                ctrl.aluop = lc3b_ctrl_pkg::alu_add;
                ctrl.offset6_sel = 1'b1;
                ctrl.mem_write = 1'b1;
                // the stored register sits in the dest field
                src2 = instr[11:9];
            end
            default: begin
                // unsupported opcodes become bubbles
                ctrl = '0;
            end
        endcase
    end

    // register file, written from writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < lc3b_types_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.ctrl.load_regfile) begin
            regs[wb.dest] <= wb.dest_data;
        end
    end

    // write-first read so a same-cycle writeback wins
    function automatic lc3b_types_pkg::lc3b_word read_reg(input lc3b_types_pkg::lc3b_reg sel);
        lc3b_types_pkg::lc3b_word value;
        value = regs[sel];
        if (wb.ctrl.load_regfile && (wb.dest == sel)) begin
            value = wb.dest_data;
        end
        return value;
    endfunction

    always_comb begin
        id_out.ctrl = ctrl;
        id_out.pc = if_id.pc;
        id_out.instruction = instr;
        id_out.dest = instr[11:9];
        id_out.src1_data = read_reg(src1);
        id_out.src2_data = read_reg(src2);
    end

endmodule : id_datapath

`default_nettype wire

//--- design/buffer.sv
`timescale 1ns/1ps
`default_nettype none

module buffer #(
    parameter type stage_t = logic
) (
    input logic clk,
    input logic rst_n,
    input logic load,
    input stage_t data_in,
    output stage_t data_out
);

    // cleared contents carry a zero control word, i.e. a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (load) begin
            data_out <= data_in;
        end
    end

endmodule : buffer

`default_nettype wire

//--- design/if_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module if_datapath (
    input logic clk,
    input logic rst_n,

    // port A, instruction side
    input logic resp_a,
    input lc3b_types_pkg::lc3b_word rdata_a,
    output logic read_a,
    output lc3b_types_pkg::lc3b_word address_a,

    input logic stall,

    // redirect from the memory stage
    input lc3b_ctrl_pkg::lc3b_pcmux_sel pcmux_sel,
    input lc3b_types_pkg::lc3b_word pc_br,

    output lc3b_ctrl_pkg::if_id_t if_out
);

    lc3b_types_pkg::lc3b_word pc;
    lc3b_types_pkg::lc3b_word pc_plus2;
    lc3b_types_pkg::lc3b_word pc_next;

    assign pc_plus2 = pc + 16'd2;

    always_comb begin
        if (pcmux_sel == lc3b_ctrl_pkg::pc_branch) begin
            pc_next = pc_br;
        end else begin
            pc_next = pc_plus2;
        end
    end

    // advance only once the fetch has returned and nothing downstream waits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (resp_a && !stall) begin
            pc <= pc_next;
        end
    end

    // fetch runs continuously
    assign read_a = 1'b1;
    assign address_a = pc;

    assign if_out.pc = pc_plus2;
    assign if_out.instruction = rdata_a;

endmodule : if_datapath

`default_nettype wire

//--- design/lc3b_ctrl_pkg.sv
`default_nettype none

package lc3b_ctrl_pkg;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    typedef enum logic {
        pc_plus2,
        pc_branch
    } lc3b_pcmux_sel;

    // an all-zero word is a bubble
    typedef struct packed {
        lc3b_types_pkg::lc3b_opcode opcode;
        lc3b_aluop aluop;
        logic imm_sel;
        logic offset6_sel;
        logic load_regfile;
        logic load_cc;
        logic mem_read;
        logic mem_write;
        logic branch;
    } lc3b_control_word;

    // pc already points past the instruction
    typedef struct packed {
        lc3b_types_pkg::lc3b_word pc;
        lc3b_types_pkg::lc3b_word instruction;
    } if_id_t;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_types_pkg::lc3b_word pc;
        lc3b_types_pkg::lc3b_word instruction;
        lc3b_types_pkg::lc3b_reg dest;
        lc3b_types_pkg::lc3b_word src1_data;
        lc3b_types_pkg::lc3b_word src2_data;
    } id_ex_t;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_types_pkg::lc3b_word pc;
        lc3b_types_pkg::lc3b_word instruction;
        lc3b_types_pkg::lc3b_reg dest;
        lc3b_types_pkg::lc3b_word alu;
        lc3b_types_pkg::lc3b_word pc_br;
        lc3b_types_pkg::lc3b_word src2_data;
    } ex_mem_t;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_types_pkg::lc3b_reg dest;
        lc3b_types_pkg::lc3b_word dest_data;
    } mem_wb_t;

endpackage : lc3b_ctrl_pkg

`default_nettype wire

//--- design/lc3b_types_pkg.sv
`default_nettype none

package lc3b_types_pkg;

    // datapath and register file sizing
    localparam int word_width = 16;
    localparam int reg_width = 3;
    localparam int reg_count = 8;
    localparam int opcode_width = 4;

    // immediate and offset field widths in the instruction word
    localparam int imm5_width = 5;
    localparam int offset6_width = 6;
    localparam int offset9_width = 9;

    typedef logic [word_width-1:0] lc3b_word;
    typedef logic [reg_width-1:0] lc3b_reg;

    // n, z, p from msb to lsb
    typedef logic [2:0] lc3b_nzp;

    // only the opcodes this core executes
    typedef enum logic [opcode_width-1:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

endpackage : lc3b_types_pkg

`default_nettype wire
